//--- hdl/dds_pkg.sv
package dds_pkg;

    // datapath widths
    localparam int SAMPLE_W = 8;
    localparam int PHASE_W = 32;
    localparam int TABLE_AW = 8;

    // fractional bits of every gain, 256 is unity
    localparam int GAIN_RADIX = 8;

    // register byte addresses
    localparam logic [31:0] ADDR_OUT_SEL = 32'h00;
    localparam logic [31:0] ADDR_RAW = 32'h04;
    localparam logic [31:0] ADDR_STEP = 32'h08;

    // frequency modulation
    localparam logic [31:0] ADDR_FM_CFG = 32'h0C;
    localparam logic [31:0] ADDR_FM_RAW = 32'h10;
    localparam logic [31:0] ADDR_FM_GAIN = 32'h14;

    // phase modulation
    localparam logic [31:0] ADDR_PM_CFG = 32'h18;
    localparam logic [31:0] ADDR_PM_RAW = 32'h1C;
    localparam logic [31:0] ADDR_PM_GAIN = 32'h20;

    // noise and output scaling
    localparam logic [31:0] ADDR_NOISE_GAIN = 32'h24;
    localparam logic [31:0] ADDR_OUT_GAIN = 32'h28;
    localparam logic [31:0] ADDR_OUT_OFFSET = 32'h2C;

    // write only, address in 15:8 and data in 7:0
    localparam logic [31:0] ADDR_TABLE = 32'h30;

    // statistics
    localparam logic [31:0] ADDR_STAT_CFG = 32'h34;
    localparam logic [31:0] ADDR_STAT_LIMIT = 32'h38;
    localparam logic [31:0] ADDR_STAT_RESULT = 32'h3C;
    localparam logic [31:0] ADDR_STAT_COUNT = 32'h40;

endpackage

//--- hdl/gain_offset_clamp.sv
`timescale 1ns/1ps

module gain_offset_clamp #(
    parameter int IN_WIDTH = 8,
    parameter int GAIN_WIDTH = 16,
    parameter int OFFSET_WIDTH = 8,
    parameter int OUT_WIDTH = 8
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic signed [IN_WIDTH-1:0]     in,
    input  logic signed [GAIN_WIDTH-1:0]   gain,
    input  logic signed [OFFSET_WIDTH-1:0] offset,
    output logic signed [OUT_WIDTH-1:0]    out
);

    localparam int PROD_W = IN_WIDTH + GAIN_WIDTH;
    // one guard bit for the offset addition
    localparam int SUM_W = PROD_W + 1;

    // output range, sign-extended to the sum width
    localparam logic signed [SUM_W-1:0] OUT_MAX =
        {{(SUM_W - OUT_WIDTH + 1){1'b0}}, {(OUT_WIDTH - 1){1'b1}}};
    localparam logic signed [SUM_W-1:0] OUT_MIN =
        {{(SUM_W - OUT_WIDTH + 1){1'b1}}, {(OUT_WIDTH - 1){1'b0}}};

    logic signed [PROD_W-1:0] product;
    logic signed [SUM_W-1:0]  sum;

    always_comb begin
        product = in * gain;
        sum = SUM_W'(product >>> dds_pkg::GAIN_RADIX) + SUM_W'(offset);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out <= '0;
        end else if (sum > OUT_MAX) begin
            out <= OUT_MAX[OUT_WIDTH-1:0];
        end else if (sum < OUT_MIN) begin
            out <= OUT_MIN[OUT_WIDTH-1:0];
        end else begin
            out <= sum[OUT_WIDTH-1:0];
        end
    end

endmodule

//--- hdl/dds_regs.sv
`timescale 1ns/1ps

module dds_regs (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [7:0]  stat_min,
    input  logic [7:0]  stat_max,
    input  logic [31:0] stat_count,
    output logic [31:0] prdata,
    output logic [1:0]  out_sel,
    output logic [7:0]  raw,
    output logic [31:0] step,
    output logic [1:0]  fm_sel,
    output logic [31:0] fm_raw,
    output logic [31:0] fm_gain,
    output logic [1:0]  pm_sel,
    output logic [31:0] pm_raw,
    output logic [31:0] pm_gain,
    output logic [15:0] noise_gain,
    output logic [15:0] out_gain,
    output logic [7:0]  out_offset,
    output logic        table_we,
    output logic [7:0]  table_addr,
    output logic [7:0]  table_data,
    output logic        stat_clear,
    output logic        stat_enable,
    output logic [31:0] stat_limit
);

    logic       wr_en;
    logic       table_hit;
    logic [1:0] stat_cfg;

    // write completes in the access phase
    assign wr_en = psel && penable && pwrite;
    assign table_hit = wr_en && (paddr == dds_pkg::ADDR_TABLE);

    assign stat_clear = stat_cfg[0];
    assign stat_enable = stat_cfg[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_sel <= '0;
            raw <= '0;
            step <= '0;
            fm_sel <= '0;
            fm_raw <= '0;
            fm_gain <= '0;
            pm_sel <= '0;
            pm_raw <= '0;
            pm_gain <= '0;
            noise_gain <= '0;
            out_gain <= '0;
            out_offset <= '0;
            stat_cfg <= '0;
            stat_limit <= '0;
        end else if (wr_en) begin
            case (paddr)
                dds_pkg::ADDR_OUT_SEL:    out_sel <= pwdata[1:0];
                dds_pkg::ADDR_RAW:        raw <= pwdata[7:0];
                dds_pkg::ADDR_STEP:       step <= pwdata;
                dds_pkg::ADDR_FM_CFG:     fm_sel <= pwdata[1:0];
                dds_pkg::ADDR_FM_RAW:     fm_raw <= pwdata;
                dds_pkg::ADDR_FM_GAIN:    fm_gain <= pwdata;
                dds_pkg::ADDR_PM_CFG:     pm_sel <= pwdata[1:0];
                dds_pkg::ADDR_PM_RAW:     pm_raw <= pwdata;
                dds_pkg::ADDR_PM_GAIN:    pm_gain <= pwdata;
                dds_pkg::ADDR_NOISE_GAIN: noise_gain <= pwdata[15:0];
                dds_pkg::ADDR_OUT_GAIN:   out_gain <= pwdata[15:0];
                dds_pkg::ADDR_OUT_OFFSET: out_offset <= pwdata[7:0];
                dds_pkg::ADDR_STAT_CFG:   stat_cfg <= pwdata[1:0];
                dds_pkg::ADDR_STAT_LIMIT: stat_limit <= pwdata;
                default: ;
            endcase
        end
    end

    // one-cycle strobe towards the waveform table
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            table_we <= 1'b0;
        end else begin
            table_we <= table_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (table_hit) begin
            table_addr <= pwdata[15:8];
            table_data <= pwdata[7:0];
        end
    end

    // readback, table register and unmapped space read 0
    always_comb begin
        prdata = '0;
        if (psel) begin
            case (paddr)
                dds_pkg::ADDR_OUT_SEL:     prdata = {30'd0, out_sel};
                dds_pkg::ADDR_RAW:         prdata = {24'd0, raw};
                dds_pkg::ADDR_STEP:        prdata = step;
                dds_pkg::ADDR_FM_CFG:      prdata = {30'd0, fm_sel};
                dds_pkg::ADDR_FM_RAW:      prdata = fm_raw;
                dds_pkg::ADDR_FM_GAIN:     prdata = fm_gain;
                dds_pkg::ADDR_PM_CFG:      prdata = {30'd0, pm_sel};
                dds_pkg::ADDR_PM_RAW:      prdata = pm_raw;
                dds_pkg::ADDR_PM_GAIN:     prdata = pm_gain;
                dds_pkg::ADDR_NOISE_GAIN:  prdata = {16'd0, noise_gain};
                dds_pkg::ADDR_OUT_GAIN:    prdata = {16'd0, out_gain};
                dds_pkg::ADDR_OUT_OFFSET:  prdata = {24'd0, out_offset};
                dds_pkg::ADDR_STAT_CFG:    prdata = {30'd0, stat_cfg};
                dds_pkg::ADDR_STAT_LIMIT:  prdata = stat_limit;
                dds_pkg::ADDR_STAT_RESULT: prdata = {16'd0, stat_max, stat_min};
                dds_pkg::ADDR_STAT_COUNT:  prdata = stat_count;
                default:                   prdata = '0;
            endcase
        end
    end

endmodule

//--- hdl/dds_core.sv
`timescale 1ns/1ps

module dds_core (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic        [dds_pkg::PHASE_W-1:0]    step,
    input  logic signed [dds_pkg::PHASE_W-1:0]    fm_data,
    input  logic signed [dds_pkg::PHASE_W-1:0]    pm_data,
    input  logic                                  table_we,
    input  logic        [dds_pkg::TABLE_AW-1:0]   table_addr,
    input  logic        [dds_pkg::SAMPLE_W-1:0]   table_data,
    output logic signed [dds_pkg::SAMPLE_W-1:0]   wave
);

    localparam int DEPTH = 2 ** dds_pkg::TABLE_AW;

    logic [dds_pkg::SAMPLE_W-1:0] table_mem [DEPTH];
    logic [dds_pkg::PHASE_W-1:0]  phase;
    logic [dds_pkg::TABLE_AW-1:0] rd_addr;

    // frequency modulation rides on top of the step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else begin
            phase <= phase + step + fm_data;
        end
    end

    // PM offsets the table index in whole entries
    assign rd_addr = phase[dds_pkg::PHASE_W-1 -: dds_pkg::TABLE_AW]
                   + pm_data[dds_pkg::TABLE_AW-1:0];

    always_ff @(posedge clk) begin
        if (table_we) begin
            table_mem[table_addr] <= table_data;
        end
    end

    // registered read, sample one cycle after the address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wave <= '0;
        end else begin
            wave <= table_mem[rd_addr];
        end
    end

endmodule

//--- hdl/prbs_gen.sv
`timescale 1ns/1ps

module prbs_gen (
    input  logic       clk,
    input  logic       arst_n,
    output logic [7:0] noise
);

    // x^8+x^6+x^5+x^4+1 in Galois form
    localparam logic [7:0] TAPS = 8'hB8;

    logic [7:0] lfsr;
    logic [7:0] lfsr_next;

    always_comb begin
        lfsr_next = {1'b0, lfsr[7:1]};
        if (lfsr[0]) begin
            lfsr_next = lfsr_next ^ TAPS;
        end
    end

    // all-ones seed, never reaches the zero lock-up state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= 8'hFF;
        end else begin
            lfsr <= lfsr_next;
        end
    end

    assign noise = lfsr;

endmodule

//--- hdl/output_mixer.sv
`timescale 1ns/1ps

module output_mixer (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [1:0]  out_sel,
    input  logic [7:0]  raw,
    input  logic [7:0]  wave,
    input  logic [7:0]  ina_data,
    input  logic [7:0]  inb_data,
    input  logic [7:0]  noise,
    input  logic [15:0] noise_gain,
    input  logic [15:0] out_gain,
    input  logic [7:0]  out_offset,
    output logic [7:0]  dds_out
);

    logic signed [7:0] selected;
    logic signed [7:0] scaled_noise;
    logic signed [8:0] wide_sum;
    logic signed [7:0] mix_sum;

    // noise scaling, in parallel with the first stage
    gain_offset_clamp #(
        .IN_WIDTH(dds_pkg::SAMPLE_W),
        .GAIN_WIDTH(16),
        .OFFSET_WIDTH(dds_pkg::SAMPLE_W),
        .OUT_WIDTH(dds_pkg::SAMPLE_W)
    ) noise_scale (
        .clk(clk),
        .arst_n(arst_n),
        .in(noise),
        .gain(noise_gain),
        .offset(8'sd0),
        .out(scaled_noise)
    );

    always_comb begin
        case (out_sel)
            2'd0:    selected = raw;
            2'd1:    selected = wave;
            2'd2:    selected = ina_data;
            default: selected = inb_data;
        endcase
        wide_sum = 9'(selected) + 9'(scaled_noise);
    end

    // stage 1, saturating add of source and noise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mix_sum <= '0;
        end else if (wide_sum[8] != wide_sum[7]) begin
            mix_sum <= wide_sum[8] ? 8'sh80 : 8'sh7F;
        end else begin
            mix_sum <= wide_sum[7:0];
        end
    end

    // stage 2
    gain_offset_clamp #(
        .IN_WIDTH(dds_pkg::SAMPLE_W),
        .GAIN_WIDTH(16),
        .OFFSET_WIDTH(dds_pkg::SAMPLE_W),
        .OUT_WIDTH(dds_pkg::SAMPLE_W)
    ) out_scale (
        .clk(clk),
        .arst_n(arst_n),
        .in(mix_sum),
        .gain(out_gain),
        .offset(out_offset),
        .out(dds_out)
    );

endmodule

//--- hdl/signal_stats.sv
`timescale 1ns/1ps

module signal_stats (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                clear,
    input  logic                                enable,
    input  logic signed [dds_pkg::SAMPLE_W-1:0] sample,
    input  logic        [31:0]                  limit,
    output logic signed [dds_pkg::SAMPLE_W-1:0] min,
    output logic signed [dds_pkg::SAMPLE_W-1:0] max,
    output logic        [31:0]                  count
);

    // extremes start at the opposite ends of the range
    localparam logic signed [dds_pkg::SAMPLE_W-1:0] S_MAX =
        {1'b0, {(dds_pkg::SAMPLE_W - 1){1'b1}}};
    localparam logic signed [dds_pkg::SAMPLE_W-1:0] S_MIN =
        {1'b1, {(dds_pkg::SAMPLE_W - 1){1'b0}}};

    logic active;

    assign active = enable && (count < limit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            min <= S_MAX;
            max <= S_MIN;
            count <= '0;
        end else if (clear) begin
            min <= S_MAX;
            max <= S_MIN;
            count <= '0;
        end else if (active) begin
            if (sample < min) begin
                min <= sample;
            end
            if (sample > max) begin
                max <= sample;
            end
            count <= count + 32'd1;
        end
    end

endmodule

//--- hdl/dds_block.sv
`timescale 1ns/1ps

module dds_block (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [7:0]  ina_data,
    input  logic [7:0]  inb_data,
    output logic [31:0] prdata,
    output logic [7:0]  dds_out
);

    logic [1:0]  out_sel;
    logic [7:0]  raw;
    logic [31:0] step;
    logic [1:0]  fm_sel;
    logic [31:0] fm_raw;
    logic [31:0] fm_gain;
    logic [1:0]  pm_sel;
    logic [31:0] pm_raw;
    logic [31:0] pm_gain;
    logic [15:0] noise_gain;
    logic [15:0] out_gain;
    logic [7:0]  out_offset;
    logic        table_we;
    logic [7:0]  table_addr;
    logic [7:0]  table_data;
    logic        stat_clear;
    logic        stat_enable;
    logic [31:0] stat_limit;
    logic [7:0]  stat_min;
    logic [7:0]  stat_max;
    logic [31:0] stat_count;
    logic [31:0] fm_src;
    logic [31:0] pm_src;
    logic [31:0] fm_data;
    logic [31:0] pm_data;
    logic [7:0]  wave;
    logic [7:0]  noise;

    dds_regs regs (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .stat_min(stat_min), .stat_max(stat_max), .stat_count(stat_count),
        .out_sel(out_sel), .raw(raw), .step(step),
        .fm_sel(fm_sel), .fm_raw(fm_raw), .fm_gain(fm_gain),
        .pm_sel(pm_sel), .pm_raw(pm_raw), .pm_gain(pm_gain),
        .noise_gain(noise_gain), .out_gain(out_gain), .out_offset(out_offset),
        .table_we(table_we), .table_addr(table_addr), .table_data(table_data),
        .stat_clear(stat_clear), .stat_enable(stat_enable), .stat_limit(stat_limit)
    );

    // modulation sources, external inputs sign-extended
    always_comb begin
        case (fm_sel)
            2'd0:    fm_src = fm_raw;
            2'd1:    fm_src = {{24{ina_data[7]}}, ina_data};
            2'd2:    fm_src = {{24{inb_data[7]}}, inb_data};
            default: fm_src = '0;
        endcase
        case (pm_sel)
            2'd0:    pm_src = pm_raw;
            2'd1:    pm_src = {{24{ina_data[7]}}, ina_data};
            2'd2:    pm_src = {{24{inb_data[7]}}, inb_data};
            default: pm_src = '0;
        endcase
    end

    gain_offset_clamp #(
        .IN_WIDTH(dds_pkg::PHASE_W), .GAIN_WIDTH(32),
        .OFFSET_WIDTH(dds_pkg::PHASE_W), .OUT_WIDTH(dds_pkg::PHASE_W)
    ) fm_scale (
        .clk(clk), .arst_n(arst_n),
        .in(fm_src), .gain(fm_gain), .offset(32'sd0), .out(fm_data)
    );

    gain_offset_clamp #(
        .IN_WIDTH(dds_pkg::PHASE_W), .GAIN_WIDTH(32),
        .OFFSET_WIDTH(dds_pkg::PHASE_W), .OUT_WIDTH(dds_pkg::PHASE_W)
    ) pm_scale (
        .clk(clk), .arst_n(arst_n),
        .in(pm_src), .gain(pm_gain), .offset(32'sd0), .out(pm_data)
    );

    dds_core core (
        .clk(clk), .arst_n(arst_n),
        .step(step), .fm_data(fm_data), .pm_data(pm_data),
        .table_we(table_we), .table_addr(table_addr), .table_data(table_data),
        .wave(wave)
    );

    prbs_gen prbs (.clk(clk), .arst_n(arst_n), .noise(noise));

    output_mixer mixer (
        .clk(clk), .arst_n(arst_n),
        .out_sel(out_sel), .raw(raw), .wave(wave),
        .ina_data(ina_data), .inb_data(inb_data),
        .noise(noise), .noise_gain(noise_gain),
        .out_gain(out_gain), .out_offset(out_offset),
        .dds_out(dds_out)
    );

    signal_stats stats (
        .clk(clk), .arst_n(arst_n),
        .clear(stat_clear), .enable(stat_enable),
        .sample(dds_out), .limit(stat_limit),
        .min(stat_min), .max(stat_max), .count(stat_count)
    );

endmodule

//--- dv/tb_dds_block.sv
`timescale 1ns/1ps

module tb_dds_block;

    // table load dominates, the other tests need well under 1200 cycles
    localparam int TABLE_LOAD_CYCLES = 256 * 3;
    localparam int TEST_CYCLES = TABLE_LOAD_CYCLES + 1200;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 1000;

    // samples in the statistics window
    localparam int STAT_WINDOW = 16;

    // read/write registers and their field widths
    localparam logic [31:0] RW_ADDR [14] = '{
        dds_pkg::ADDR_OUT_SEL, dds_pkg::ADDR_RAW, dds_pkg::ADDR_STEP,
        dds_pkg::ADDR_FM_CFG, dds_pkg::ADDR_FM_RAW, dds_pkg::ADDR_FM_GAIN,
        dds_pkg::ADDR_PM_CFG, dds_pkg::ADDR_PM_RAW, dds_pkg::ADDR_PM_GAIN,
        dds_pkg::ADDR_NOISE_GAIN, dds_pkg::ADDR_OUT_GAIN, dds_pkg::ADDR_OUT_OFFSET,
        dds_pkg::ADDR_STAT_CFG, dds_pkg::ADDR_STAT_LIMIT
    };
    localparam logic [31:0] RW_MASK [14] = '{
        32'h3, 32'hFF, 32'hFFFF_FFFF, 32'h3, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
        32'h3, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF, 32'hFFFF, 32'hFF,
        32'h3, 32'hFFFF_FFFF
    };

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [7:0]  ina_data;
    logic [7:0]  inb_data;
    logic [31:0] prdata;
    logic [7:0]  dds_out;

    int checks;
    int errors;
    int cycles;
    int seed;
    logic recording;
    logic signed [7:0] recorded [$];

    dds_block DUT (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .ina_data(ina_data), .inb_data(inb_data),
        .prdata(prdata), .dds_out(dds_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("Test failures found");
            $finish;
        end
    end

    // output samples while the statistics window is open
    always @(negedge clk) begin
        if (recording && recorded.size() < STAT_WINDOW) begin
            recorded.push_back(dds_out);
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // prdata is combinational, take it mid-cycle
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic sample_out(output logic [7:0] value);
        @(negedge clk);
        value = dds_out;
    endtask

    // reference for the output stage: multiply, shift by 8, offset, saturate
    function automatic int scale_clamp(input int x, input int gain, input int offset);
        int v;
        v = ((x * gain) >>> 8) + offset;
        if (v > 127) begin
            v = 127;
        end else if (v < -128) begin
            v = -128;
        end
        return v;
    endfunction

    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        logic [7:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 8'hB8;
        end
        return next;
    endfunction

    task automatic expect_increment(input string name, input logic [7:0] inc, input int n);
        logic [7:0] prev;
        logic [7:0] cur;
        wait_cycles(6);
        sample_out(prev);
        repeat (n) begin
            sample_out(cur);
            check(name, {24'd0, 8'(cur - prev)}, {24'd0, inc});
            prev = cur;
        end
    endtask

    task automatic reset_defaults();
        logic [31:0] rd;
        logic [7:0] v;
        sample_out(v);
        check("dds_out after reset", {24'd0, v}, 32'd0);
        apb_read(dds_pkg::ADDR_OUT_GAIN, rd);
        check("out_gain after reset", rd, 32'd0);
    endtask

    task automatic register_readback();
        logic [31:0] wrote [14];
        logic [31:0] rd;
        logic [31:0] holes [4];
        holes = '{dds_pkg::ADDR_TABLE, 32'h44, 32'h80, 32'hFFC};
        for (int i = 0; i < 14; i++) begin
            wrote[i] = $urandom;
            apb_write(RW_ADDR[i], wrote[i]);
        end
        for (int i = 0; i < 14; i++) begin
            apb_read(RW_ADDR[i], rd);
            check($sformatf("prdata @0x%02h", RW_ADDR[i]), rd, wrote[i] & RW_MASK[i]);
        end
        foreach (holes[i]) begin
            apb_read(holes[i], rd);
            check($sformatf("prdata @0x%0h", holes[i]), rd, 32'd0);
        end
        // back to the reset state
        for (int i = 0; i < 14; i++) begin
            apb_write(RW_ADDR[i], 32'd0);
        end
    endtask

    task automatic dc_gain_path();
        logic [1:0] sel [3];
        logic [7:0] src;
        logic [7:0] offs;
        logic [7:0] got;
        int gain;
        int expd;
        sel = '{2'd0, 2'd2, 2'd3};
        apb_write(dds_pkg::ADDR_NOISE_GAIN, 32'd0);
        foreach (sel[k]) begin
            apb_write(dds_pkg::ADDR_OUT_SEL, {30'd0, sel[k]});
            repeat (6) begin
                src = 8'($urandom);
                offs = 8'($urandom);
                gain = int'($urandom_range(0, 1279)) - 512;
                if (k == 0) begin
                    apb_write(dds_pkg::ADDR_RAW, {24'd0, src});
                end else begin
                    @(posedge clk);
                    if (k == 1) begin
                        ina_data <= src;
                    end else begin
                        inb_data <= src;
                    end
                end
                apb_write(dds_pkg::ADDR_OUT_GAIN, gain);
                apb_write(dds_pkg::ADDR_OUT_OFFSET, {24'd0, offs});
                wait_cycles(4);
                sample_out(got);
                expd = scale_clamp(int'($signed(src)), gain, int'($signed(offs)));
                check($sformatf("dds_out sel %0d", sel[k]), {24'd0, got},
                      {24'd0, 8'(expd)});
            end
        end
    endtask

    task automatic waveform_ramp();
        for (int i = 0; i < 256; i++) begin
            // entry i holds i-128
            apb_write(dds_pkg::ADDR_TABLE, {16'd0, 8'(i), 8'(i) ^ 8'h80});
        end
        apb_write(dds_pkg::ADDR_NOISE_GAIN, 32'd0);
        apb_write(dds_pkg::ADDR_OUT_GAIN, 32'd256);
        apb_write(dds_pkg::ADDR_OUT_OFFSET, 32'd0);
        apb_write(dds_pkg::ADDR_STEP, 32'h0100_0000);
        apb_write(dds_pkg::ADDR_OUT_SEL, 32'd1);
        expect_increment("dds_out ramp step 1", 8'd1, 20);
        apb_write(dds_pkg::ADDR_STEP, 32'h0200_0000);
        expect_increment("dds_out ramp step 2", 8'd2, 20);
    endtask

    task automatic modulation();
        logic [7:0] v0;
        logic [7:0] v1;
        apb_write(dds_pkg::ADDR_STEP, 32'd0);
        apb_write(dds_pkg::ADDR_PM_CFG, 32'd0);
        apb_write(dds_pkg::ADDR_PM_GAIN, 32'd256);
        apb_write(dds_pkg::ADDR_PM_RAW, 32'd0);
        wait_cycles(6);
        sample_out(v0);
        sample_out(v1);
        // phase frozen with step 0
        check("dds_out steady", {24'd0, v1}, {24'd0, v0});
        apb_write(dds_pkg::ADDR_PM_RAW, 32'd5);
        wait_cycles(6);
        sample_out(v1);
        check("dds_out pm shift", {24'd0, 8'(v1 - v0)}, 32'd5);
        apb_write(dds_pkg::ADDR_PM_RAW, 32'd0);
        apb_write(dds_pkg::ADDR_FM_CFG, 32'd0);
        apb_write(dds_pkg::ADDR_FM_GAIN, 32'd256);
        apb_write(dds_pkg::ADDR_FM_RAW, 32'h0100_0000);
        expect_increment("dds_out fm step 1", 8'd1, 20);
        apb_write(dds_pkg::ADDR_FM_RAW, 32'd0);
    endtask

    task automatic noise_lfsr();
        logic [7:0] prev;
        logic [7:0] cur;
        apb_write(dds_pkg::ADDR_OUT_SEL, 32'd0);
        apb_write(dds_pkg::ADDR_RAW, 32'd0);
        apb_write(dds_pkg::ADDR_OUT_OFFSET, 32'd0);
        apb_write(dds_pkg::ADDR_OUT_GAIN, 32'd256);
        apb_write(dds_pkg::ADDR_NOISE_GAIN, 32'd256);
        wait_cycles(4);
        sample_out(prev);
        // a running LFSR never holds zero
        check("dds_out noise is zero", {31'd0, prev == 8'd0}, 32'd0);
        repeat (32) begin
            sample_out(cur);
            check("dds_out noise", {24'd0, cur}, {24'd0, lfsr_step(prev)});
            prev = cur;
        end
        apb_write(dds_pkg::ADDR_NOISE_GAIN, 32'd0);
    endtask

    task automatic statistics_window();
        logic [31:0] rd;
        logic [7:0] v;
        logic signed [7:0] lo;
        logic signed [7:0] hi;
        apb_write(dds_pkg::ADDR_OUT_SEL, 32'd1);
        apb_write(dds_pkg::ADDR_STEP, 32'h0100_0000);
        apb_write(dds_pkg::ADDR_STAT_CFG, 32'd1);
        apb_write(dds_pkg::ADDR_STAT_LIMIT, STAT_WINDOW);
        apb_write(dds_pkg::ADDR_STAT_CFG, 32'd0);
        apb_read(dds_pkg::ADDR_STAT_COUNT, rd);
        check("stat_count after clear", rd, 32'd0);
        apb_read(dds_pkg::ADDR_STAT_RESULT, rd);
        check("stat result after clear", rd, {16'd0, 8'h80, 8'h7F});
        // start low on the ramp so the window does not wrap
        wait_cycles(6);
        sample_out(v);
        while ($signed(v) > 8'sd90) begin
            sample_out(v);
        end
        recorded.delete();
        apb_write(dds_pkg::ADDR_STAT_CFG, 32'd2);
        recording = 1'b1;
        rd = '0;
        while (rd < STAT_WINDOW) begin
            apb_read(dds_pkg::ADDR_STAT_COUNT, rd);
        end
        recording = 1'b0;
        check("stat_count", rd, STAT_WINDOW);
        lo = recorded[0];
        hi = recorded[0];
        foreach (recorded[i]) begin
            if (recorded[i] < lo) begin
                lo = recorded[i];
            end
            if (recorded[i] > hi) begin
                hi = recorded[i];
            end
        end
        apb_read(dds_pkg::ADDR_STAT_RESULT, rd);
        check("stat_min", {24'd0, rd[7:0]}, {24'd0, lo});
        check("stat_max", {24'd0, rd[15:8]}, {24'd0, hi});
        check("stat_max - stat_min", {24'd0, 8'(rd[15:8] - rd[7:0])}, 32'd15);
        // count stops at the limit
        wait_cycles(8);
        apb_read(dds_pkg::ADDR_STAT_COUNT, rd);
        check("stat_count held", rd, STAT_WINDOW);
    endtask

    initial begin
        seed = 32'h57f4;
        void'($urandom(seed));
        arst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        ina_data = '0;
        inb_data = '0;
        recording = 1'b0;
        checks = 0;
        errors = 0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        reset_defaults();
        register_readback();
        dc_gain_path();
        waveform_ramp();
        modulation();
        noise_lfsr();
        statistics_window();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- flist.f
hdl/dds_pkg.sv
hdl/gain_offset_clamp.sv
hdl/dds_regs.sv
hdl/dds_core.sv
hdl/prbs_gen.sv
hdl/output_mixer.sv
hdl/signal_stats.sv
hdl/dds_block.sv
dv/tb_dds_block.sv

//--- Makefile
TOP = tb_dds_block

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log
